// ==== hdl/mf_pkg.sv ====
package mf_pkg;

    ////////////////////////////////////////
    // Widths and window sizes
    ////////////////////////////////////////

    // Signed ADC sample from the band-pass path
    localparam int sample_w   = 4;
    // Signed template coefficient, amplitude 15
    localparam int coef_w     = 5;
    localparam int window_len = 16;
    // Newest samples used for 802.15.4
    localparam int short_len  = 8;
    // Sum of 16 products of 9 bits
    localparam int corr_w     = 13;
    // Sum of four squared correlations
    localparam int energy_w   = 27;

    ////////////////////////////////////////
    // Mode select codes
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        mode_ble_2_3    = 2'd0,
        mode_zigbee_2_3 = 2'd1,
        mode_ble_15_2   = 2'd2,
        mode_ble_1_15   = 2'd3
    } mode_e;

    ////////////////////////////////////////
    // Sample and template types
    ////////////////////////////////////////

    typedef struct packed {
        logic signed [sample_w-1:0] i;
        logic signed [sample_w-1:0] q;
    } iq_sample_t;

    // Element 0 oldest, element window_len-1 newest
    typedef iq_sample_t [window_len-1:0] iq_window_t;

    typedef logic signed [coef_w-1:0] coef_t;

    // Ascending range so table literals read in time order
    typedef coef_t [0:window_len-1] coef_vec_t;

    typedef struct packed {
        coef_vec_t cos;
        coef_vec_t sin;
    } tone_coefs_t;

    ////////////////////////////////////////
    // Tone tables, 16 samples at 16 MHz
    ////////////////////////////////////////

    localparam tone_coefs_t tpl_1mhz = '{
        cos: '{ 15,  14,  11,   6,   0,  -6, -11, -14,
               -15, -14, -11,  -6,   0,   6,  11,  14},
        sin: '{  0,   6,  11,  14,  15,  14,  11,   6,
                 0,  -6, -11, -14, -15, -14, -11,  -6}
    };

    localparam tone_coefs_t tpl_15mhz = '{
        cos: '{ 15,  12,   6,  -3, -11, -15, -14,  -8,
                 0,   8,  14,  15,  11,   3,  -6, -12},
        sin: '{  0,   8,  14,  15,  11,   3,  -6, -12,
               -15, -12,  -6,   3,  11,  15,  14,   8}
    };

    localparam tone_coefs_t tpl_2mhz = '{
        cos: '{ 15,  11,   0, -11, -15, -11,   0,  11,
                15,  11,   0, -11, -15, -11,   0,  11},
        sin: '{  0,  11,  15,  11,   0, -11, -15, -11,
                 0,  11,  15,  11,   0, -11, -15, -11}
    };

    // Also the 802.15.4 high tone, first 8 entries only
    localparam tone_coefs_t tpl_3mhz = '{
        cos: '{ 15,   6, -11, -14,   0,  14,  11,  -6,
               -15,  -6,  11,  14,   0, -14, -11,   6},
        sin: '{  0,  14,  11,  -6, -15,  -6,  11,  14,
                 0, -14, -11,   6,  15,   6, -11, -14}
    };

endpackage

// ==== hdl/sample_window.sv ====
`timescale 1ns/1ps

module sample_window (
    input  logic                   clk,
    input  logic                   rst,
    input  mf_pkg::iq_sample_t     sample,
    output mf_pkg::iq_window_t     win
);

    ////////////////////////////////////////
    // I/Q delay line
    ////////////////////////////////////////

    // One new pair per clock, no handshake
    // Oldest pair falls off element 0, newest lands in the top element
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            win <= '0;
        end else begin
            for (int n = 0; n < mf_pkg::window_len - 1; n++) begin
                win[n] <= win[n+1];
            end
            win[mf_pkg::window_len-1] <= sample;
        end
    end

endmodule

// ==== hdl/template_select.sv ====
`timescale 1ns/1ps

module template_select (
    input  mf_pkg::mode_e          mode,
    output mf_pkg::tone_coefs_t    low_coefs,
    output mf_pkg::tone_coefs_t    high_coefs
);

    // Move template entries 0..short_len-1 onto the newest window slots
    // and clear the older slots, so the correlator sees a short window
    function automatic mf_pkg::tone_coefs_t align_short(input mf_pkg::tone_coefs_t full);
        mf_pkg::tone_coefs_t res;
        res = '0;
        for (int n = 0; n < mf_pkg::short_len; n++) begin
            res.cos[n + mf_pkg::window_len - mf_pkg::short_len] = full.cos[n];
            res.sin[n + mf_pkg::window_len - mf_pkg::short_len] = full.sin[n];
        end
        return res;
    endfunction

    ////////////////////////////////////////
    // Tone pair per mode
    ////////////////////////////////////////

    always_comb begin
        case (mode)
            mf_pkg::mode_zigbee_2_3: begin
                low_coefs  = align_short(mf_pkg::tpl_2mhz);
                high_coefs = align_short(mf_pkg::tpl_3mhz);
            end
            mf_pkg::mode_ble_15_2: begin
                low_coefs  = mf_pkg::tpl_15mhz;
                high_coefs = mf_pkg::tpl_2mhz;
            end
            mf_pkg::mode_ble_1_15: begin
                low_coefs  = mf_pkg::tpl_1mhz;
                high_coefs = mf_pkg::tpl_15mhz;
            end
            // BLE 2/3 MHz, the default pair
            default: begin
                low_coefs  = mf_pkg::tpl_2mhz;
                high_coefs = mf_pkg::tpl_3mhz;
            end
        endcase
    end

endmodule

// ==== hdl/tone_correlator.sv ====
`timescale 1ns/1ps

module tone_correlator (
    input  logic                           clk,
    input  logic                           rst,
    input  mf_pkg::iq_window_t             win,
    input  mf_pkg::tone_coefs_t            coefs,
    output logic [mf_pkg::energy_w-1:0]    energy
);

    logic signed [mf_pkg::corr_w-1:0]  i_cos;
    logic signed [mf_pkg::corr_w-1:0]  i_sin;
    logic signed [mf_pkg::corr_w-1:0]  q_cos;
    logic signed [mf_pkg::corr_w-1:0]  q_sin;

    // Squares are never negative, kept as plain magnitudes
    logic [2*mf_pkg::corr_w-1:0]       sq_i_cos;
    logic [2*mf_pkg::corr_w-1:0]       sq_i_sin;
    logic [2*mf_pkg::corr_w-1:0]       sq_q_cos;
    logic [2*mf_pkg::corr_w-1:0]       sq_q_sin;
    logic [mf_pkg::energy_w-1:0]       energy_next;

    ////////////////////////////////////////
    // Four correlations over the window
    ////////////////////////////////////////

    // Zero coefficients drop their window slot out of the sum
    always_comb begin
        i_cos = '0;
        i_sin = '0;
        q_cos = '0;
        q_sin = '0;
        for (int n = 0; n < mf_pkg::window_len; n++) begin
            i_cos = i_cos + $signed(win[n].i) * $signed(coefs.cos[n]);
            i_sin = i_sin + $signed(win[n].i) * $signed(coefs.sin[n]);
            q_cos = q_cos + $signed(win[n].q) * $signed(coefs.cos[n]);
            q_sin = q_sin + $signed(win[n].q) * $signed(coefs.sin[n]);
        end
    end

    // Squared magnitude, phase independent
    assign sq_i_cos = i_cos * i_cos;
    assign sq_i_sin = i_sin * i_sin;
    assign sq_q_cos = q_cos * q_cos;
    assign sq_q_sin = q_sin * q_sin;

    assign energy_next = sq_i_cos + sq_i_sin + sq_q_cos + sq_q_sin;

    // Pipeline stage ahead of the decision
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            energy <= '0;
        end else begin
            energy <= energy_next;
        end
    end

endmodule

// ==== hdl/fsk_decision.sv ====
`timescale 1ns/1ps

module fsk_decision (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           update,
    input  logic [mf_pkg::energy_w-1:0]    low_energy,
    input  logic [mf_pkg::energy_w-1:0]    high_energy,
    output logic                           data
);

    logic low_wins;

    // Low tone must be strictly stronger, a tie reads as 1
    assign low_wins = (low_energy > high_energy);

    // Bit only moves on the update strobe
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            data <= 1'b0;
        end else if (update) begin
            data <= ~low_wins;
        end
    end

endmodule

// ==== hdl/matched_filter_top.sv ====
`timescale 1ns/1ps

module matched_filter_top (
    input  logic                   clk,
    input  logic                   rst,
    input  mf_pkg::mode_e          mode,
    input  logic                   update,
    input  mf_pkg::iq_sample_t     sample,
    output logic                   data
);

    mf_pkg::iq_window_t            win;
    mf_pkg::tone_coefs_t           low_coefs;
    mf_pkg::tone_coefs_t           high_coefs;
    logic [mf_pkg::energy_w-1:0]   low_energy;
    logic [mf_pkg::energy_w-1:0]   high_energy;

    sample_window u_window (
        .clk    (clk),
        .rst    (rst),
        .sample (sample),
        .win    (win)
    );

    template_select u_templates (
        .mode       (mode),
        .low_coefs  (low_coefs),
        .high_coefs (high_coefs)
    );

    ////////////////////////////////////////
    // One correlator per tone
    ////////////////////////////////////////

    tone_correlator low_corr (
        .clk    (clk),
        .rst    (rst),
        .win    (win),
        .coefs  (low_coefs),
        .energy (low_energy)
    );

    tone_correlator high_corr (
        .clk    (clk),
        .rst    (rst),
        .win    (win),
        .coefs  (high_coefs),
        .energy (high_energy)
    );

    fsk_decision u_decision (
        .clk         (clk),
        .rst         (rst),
        .update      (update),
        .low_energy  (low_energy),
        .high_energy (high_energy),
        .data        (data)
    );

endmodule

// ==== bench/mf_model.svh ====
`ifndef MF_MODEL_SVH
`define MF_MODEL_SVH

////////////////////////////////////////
// Reference model of the demodulator
////////////////////////////////////////

// Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 32'h8020_0003;
    end
    return n;
endfunction

// Low or high tone of a mode, 802.15.4 shares the 2/3 MHz pair
function automatic mf_pkg::tone_coefs_t tone_of(input mf_pkg::mode_e m, input logic high);
    case (m)
        mf_pkg::mode_ble_15_2: return high ? mf_pkg::tpl_2mhz : mf_pkg::tpl_15mhz;
        mf_pkg::mode_ble_1_15: return high ? mf_pkg::tpl_15mhz : mf_pkg::tpl_1mhz;
        default:               return high ? mf_pkg::tpl_3mhz : mf_pkg::tpl_2mhz;
    endcase
endfunction

// Sum of four squared correlations
// Short window pairs template entries 0..7 with the newest 8 samples
function automatic longint tone_energy(input mf_pkg::tone_coefs_t t,
                                       input mf_pkg::iq_window_t w,
                                       input logic short_win);
    longint i_c;
    longint i_s;
    longint q_c;
    longint q_s;
    int     k;
    int     c;
    int     s;
    int     xi;
    int     xq;
    i_c = 0;
    i_s = 0;
    q_c = 0;
    q_s = 0;
    for (int p = 0; p < 16; p++) begin
        k = short_win ? p - 8 : p;
        if (k >= 0) begin
            c   = $signed(t.cos[k]);
            s   = $signed(t.sin[k]);
            xi  = $signed(w[p].i);
            xq  = $signed(w[p].q);
            i_c += xi * c;
            i_s += xi * s;
            q_c += xq * c;
            q_s += xq * s;
        end
    end
    return i_c * i_c + i_s * i_s + q_c * q_c + q_s * q_s;
endfunction

// Expected bit, low strictly stronger gives 0
function automatic logic expected_bit(input mf_pkg::mode_e m, input mf_pkg::iq_window_t w);
    logic   short_win;
    longint low_e;
    longint high_e;
    short_win = (m == mf_pkg::mode_zigbee_2_3);
    low_e     = tone_energy(tone_of(m, 1'b0), w, short_win);
    high_e    = tone_energy(tone_of(m, 1'b1), w, short_win);
    return (low_e > high_e) ? 1'b0 : 1'b1;
endfunction

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
        $display("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
        $display("test failed");
        $fatal(1);
    end
endtask

`endif

// ==== bench/matched_filter_tb.sv ====
`timescale 1ns/1ps

module matched_filter_tb;

    typedef struct packed {
        mf_pkg::mode_e mode;
        logic          high_tone;
        // Quarter turn applied to the tone when set
        logic          quadrant;
        logic          expected;
    } row_t;

    localparam int num_rows   = 16;
    localparam int max_cycles = 20000;

    logic               clk;
    logic               rst;
    mf_pkg::mode_e      mode;
    logic               update;
    mf_pkg::iq_sample_t sample;
    logic               data;
    row_t               rows [num_rows];
    logic [31:0]        lfsr_state;

    `include "mf_model.svh"

    matched_filter_top dut (
        .clk    (clk),
        .rst    (rst),
        .mode   (mode),
        .update (update),
        .sample (sample),
        .data   (data)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Run limit
    initial begin
        for (int n = 0; n < max_cycles; n++) begin
            @(posedge clk);
        end
        $display("simulation did not finish within %0d cycles", max_cycles);
        $display("test failed");
        $fatal(1);
    end

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] res;
        res = '0;
        for (int k = 0; k < n; k++) begin
            res        = {res[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return res;
    endfunction

    // Quarter turn on the table tone then scale down to 4 bits
    function automatic mf_pkg::iq_window_t make_tone(input mf_pkg::tone_coefs_t t,
                                                     input logic quadrant);
        mf_pkg::iq_window_t w;
        int c;
        int s;
        int ri;
        int rq;
        for (int k = 0; k < 16; k++) begin
            c = $signed(t.cos[k]);
            s = $signed(t.sin[k]);
            if (quadrant) begin
                ri = -s;
                rq = c;
            end else begin
                ri = c;
                rq = s;
            end
            ri = ri >>> 2;
            rq = rq >>> 2;
            w[k].i = ri[3:0];
            w[k].q = rq[3:0];
        end
        return w;
    endfunction

    ////////////////////////////////////////
    // Drive helpers
    ////////////////////////////////////////

    // Lead samples go first and the 16 window samples follow oldest first
    task automatic drive_samples(input mf_pkg::mode_e m, input mf_pkg::iq_window_t w,
                                 input int lead);
        int idx;
        for (int k = 0; k < lead + 16; k++) begin
            idx = (k + 16 - lead) % 16;
            @(posedge clk);
            mode   <= m;
            sample <= w[idx];
        end
    endtask

    // Gap cycle lets the energy register catch the full window
    task automatic pulse_update;
        @(posedge clk);
        sample <= '0;
        @(posedge clk);
        update <= 1'b1;
        @(posedge clk);
        update <= 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
        end
    endtask

    task automatic check_data(input logic expected);
        @(negedge clk);
        check_value("data", data, expected);
    endtask

    task automatic load_table;
        rows[0]  = {mf_pkg::mode_ble_2_3,    1'b0, 1'b0, 1'b0};
        rows[1]  = {mf_pkg::mode_ble_2_3,    1'b1, 1'b0, 1'b1};
        rows[2]  = {mf_pkg::mode_ble_2_3,    1'b0, 1'b1, 1'b0};
        rows[3]  = {mf_pkg::mode_ble_2_3,    1'b1, 1'b1, 1'b1};
        rows[4]  = {mf_pkg::mode_zigbee_2_3, 1'b0, 1'b0, 1'b0};
        rows[5]  = {mf_pkg::mode_zigbee_2_3, 1'b1, 1'b0, 1'b1};
        rows[6]  = {mf_pkg::mode_zigbee_2_3, 1'b0, 1'b1, 1'b0};
        rows[7]  = {mf_pkg::mode_zigbee_2_3, 1'b1, 1'b1, 1'b1};
        rows[8]  = {mf_pkg::mode_ble_15_2,   1'b0, 1'b0, 1'b0};
        rows[9]  = {mf_pkg::mode_ble_15_2,   1'b1, 1'b0, 1'b1};
        rows[10] = {mf_pkg::mode_ble_15_2,   1'b0, 1'b1, 1'b0};
        rows[11] = {mf_pkg::mode_ble_15_2,   1'b1, 1'b1, 1'b1};
        rows[12] = {mf_pkg::mode_ble_1_15,   1'b0, 1'b0, 1'b0};
        rows[13] = {mf_pkg::mode_ble_1_15,   1'b1, 1'b0, 1'b1};
        rows[14] = {mf_pkg::mode_ble_1_15,   1'b0, 1'b1, 1'b0};
        rows[15] = {mf_pkg::mode_ble_1_15,   1'b1, 1'b1, 1'b1};
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin : stimulus
        mf_pkg::iq_window_t w;
        mf_pkg::iq_window_t w2;
        mf_pkg::mode_e      m;
        row_t               r;
        logic               exp;
        logic [31:0]        bits;
        rst        <= 1'b0;
        mode       <= mf_pkg::mode_ble_2_3;
        update     <= 1'b0;
        sample     <= '0;
        lfsr_state = 32'h1ea1698d;
        load_table();
        wait_cycles(2);
        rst <= 1'b1;
        wait_cycles(2);
        check_data(1'b0);

        // Steady tones in every mode
        for (int n = 0; n < num_rows; n++) begin
            r = rows[n];
            w = make_tone(tone_of(r.mode, r.high_tone), r.quadrant);
            check_value("expected_bit", expected_bit(r.mode, w), r.expected);
            drive_samples(r.mode, w, 4);
            pulse_update();
            wait_cycles(3);
            check_data(r.expected);
        end

        // Bit holds through a low tone until the next update
        w = make_tone(mf_pkg::tpl_3mhz, 1'b0);
        drive_samples(mf_pkg::mode_ble_2_3, w, 4);
        pulse_update();
        wait_cycles(3);
        check_data(1'b1);
        w = make_tone(mf_pkg::tpl_2mhz, 1'b0);
        drive_samples(mf_pkg::mode_ble_2_3, w, 4);
        check_data(1'b1);
        pulse_update();
        wait_cycles(3);
        check_data(1'b0);

        // In 802.15.4 mode the newest 8 samples decide
        for (int hi_new = 0; hi_new < 2; hi_new++) begin
            w  = make_tone(tone_of(mf_pkg::mode_zigbee_2_3, hi_new == 0), 1'b0);
            w2 = make_tone(tone_of(mf_pkg::mode_zigbee_2_3, hi_new == 1), 1'b0);
            for (int k = 8; k < 16; k++) begin
                w[k] = w2[k-8];
            end
            exp = expected_bit(mf_pkg::mode_zigbee_2_3, w);
            check_value("expected_bit", exp, hi_new);
            drive_samples(mf_pkg::mode_zigbee_2_3, w, 0);
            pulse_update();
            wait_cycles(3);
            check_data(exp);
        end

        // Random windows and modes
        for (int n = 0; n < 40; n++) begin
            bits = draw_bits(2);
            m    = mf_pkg::mode_e'(bits[1:0]);
            for (int p = 0; p < 16; p++) begin
                bits    = draw_bits(4);
                w[p].i  = bits[3:0];
                bits    = draw_bits(4);
                w[p].q  = bits[3:0];
            end
            exp = expected_bit(m, w);
            drive_samples(m, w, 0);
            pulse_update();
            wait_cycles(3);
            check_data(exp);
        end

        // Reset in the middle of a stream
        w = make_tone(mf_pkg::tpl_3mhz, 1'b0);
        drive_samples(mf_pkg::mode_ble_2_3, w, 4);
        pulse_update();
        wait_cycles(3);
        check_data(1'b1);
        #2;
        rst <= 1'b0;
        #1;
        check_value("data", data, 1'b0);
        @(posedge clk);
        rst <= 1'b1;
        for (int k = 0; k < 18; k++) begin
            @(posedge clk);
            sample <= w[k % 16];
            @(negedge clk);
            check_value("data", data, 1'b0);
        end

        $display("test passed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+bench
hdl/mf_pkg.sv
hdl/sample_window.sv
hdl/template_select.sv
hdl/tone_correlator.sv
hdl/fsk_decision.sv
hdl/matched_filter_top.sv
bench/matched_filter_tb.sv
